//--- all.f
+incdir+hw
hw/DispatchTypes.sv
hw/DispatchStageIF.sv
hw/DispatchController.sv
hw/IssueQueueAllocator.sv
hw/DispatchStage.sv
hw/IssueQueuePayload.sv
hw/DispatchTop.sv
test/DispatchChecker.sv
test/DispatchTest.sv

//--- Makefile
# Verilator build and run of the dispatch testbench

TOP := DispatchTest

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f all.f --top-module $(TOP) -Mdir obj_dir -o simv
	./obj_dir/simv | tee sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- test/DispatchTest.sv
// Testbench for the dispatch top level
// Ops come from a table run test by test and DispatchChecker does the comparing
// One raw field feeds every class-dependent rename input at once

`include "dispatch_settings.svh"

module DispatchTest;
    import DispatchTypes::*;

    // issueReady patterns
    localparam int ReadyHigh = 0;
    localparam int ReadyLow = 1;
    localparam int ReadyRandom = 2;
    localparam int ReadyUntilStall = 3;

    typedef struct packed {
        int test;
        OpClass opClass;
        OperandType typeA;
        OperandType typeB;
        logic writeReg;
        PhyRegNum dst;
        PhyRegNum srcA;
        PhyRegNum srcB;
        logic [`SUB_INFO_WIDTH-1:0] raw;
        ProgramCounter pc;
        int gap;
        bit flushBefore;
    } OpRecord;

    logic ctrl;
    logic arstN;
    logic flush;
    logic renValid;
    logic renReady;
    OpClass renOpClass;
    OperandType renOperandTypeA;
    OperandType renOperandTypeB;
    logic renWriteReg;
    PhyRegNum renPhySrcA;
    PhyRegNum renPhySrcB;
    PhyRegNum renPhyDst;
    AluCode renAluCode;
    ShiftType renShiftType;
    BrDisp renBrDisp;
    MemAccessMode renMemMode;
    logic renIsLoad;
    ProgramCounter renPc;
    logic issueValid;
    IssueQueueEntry issueEntry;
    logic issueReady;
    int errorCount;
    int checkCount;
    int pendingCount;

    OpRecord opTable[$];
    bit tableBuilt = 1'b0;
    int readyMode = ReadyHigh;
    int holdLeft = 0;
    bit stallSeen = 1'b0;
    int stallCycles = 0;
    int testCount = 0;

    DispatchTop uut (.*);

    DispatchChecker watch (.*);

    initial begin
        ctrl = 1'b0;
        forever #50 ctrl = ~ctrl;
    end

    function automatic OpRecord makeOp(input int test, input OpClass cls,
            input OperandType ta, input OperandType tb, input logic wr,
            input PhyRegNum dst, input PhyRegNum srcA, input PhyRegNum srcB,
            input logic [`SUB_INFO_WIDTH-1:0] raw, input ProgramCounter pc,
            input int gap, input bit flushBefore);
        OpRecord op;
        op.test = test;
        op.opClass = cls;
        op.typeA = ta;
        op.typeB = tb;
        op.writeReg = wr;
        op.dst = dst;
        op.srcA = srcA;
        op.srcB = srcB;
        op.raw = raw;
        op.pc = pc;
        op.gap = gap;
        op.flushBefore = flushBefore;
        return op;
    endfunction

    function automatic OpClass classOf(input int n);
        case (n % 3)
            0: return OP_CLASS_INT;
            1: return OP_CLASS_BR;
            default: return OP_CLASS_MEM;
        endcase
    endfunction

    // Fields spread out from the test and index, so neighbours differ
    function automatic OpRecord patternOp(input int test, input int i, input bit flushBefore);
        int k;
        k = test * 16 + i;
        return makeOp(test, classOf(i), OperandType'(k[0]), OperandType'(k[1]), k[2],
            PhyRegNum'(k), PhyRegNum'(k + 1), PhyRegNum'(k + 2), 12'(k * 37 + 5),
            ProgramCounter'(k * 4), 0, flushBefore);
    endfunction

    function automatic OpRecord randomOp(input int test);
        logic [31:0] r;
        logic [31:0] s;
        r = $urandom;
        s = $urandom;
        return makeOp(test, classOf(int'(r % 3)), OperandType'(r[2]), OperandType'(r[3]),
            r[4], r[10:5], r[16:11], r[22:17], s[11:0], s[27:12], int'(s[31:30]), 1'b0);
    endfunction

    task automatic buildTable();
        opTable.push_back(makeOp(1, OP_CLASS_INT, OPERAND_REG, OPERAND_REG, 1'b1,
            6'd3, 6'd1, 6'd2, 12'h021, 16'h0010, 0, 1'b0));
        // Every raw bit set somewhere, so missing padding shows up
        opTable.push_back(makeOp(2, OP_CLASS_INT, OPERAND_REG, OPERAND_REG, 1'b1,
            6'd5, 6'd1, 6'd2, 12'hfff, 16'h0100, 1, 1'b0));
        opTable.push_back(makeOp(2, OP_CLASS_INT, OPERAND_REG, OPERAND_IMM, 1'b1,
            6'd6, 6'd3, 6'd63, 12'ha5a, 16'h0104, 0, 1'b0));
        opTable.push_back(makeOp(2, OP_CLASS_BR, OPERAND_IMM, OPERAND_REG, 1'b0,
            6'd0, 6'd7, 6'd8, 12'habc, 16'h0108, 2, 1'b0));
        opTable.push_back(makeOp(2, OP_CLASS_BR, OPERAND_IMM, OPERAND_IMM, 1'b0,
            6'd0, 6'd9, 6'd10, 12'h801, 16'h010c, 0, 1'b0));
        opTable.push_back(makeOp(2, OP_CLASS_MEM, OPERAND_REG, OPERAND_IMM, 1'b1,
            6'd11, 6'd12, 6'd13, 12'hfff, 16'h0110, 1, 1'b0));
        opTable.push_back(makeOp(2, OP_CLASS_MEM, OPERAND_REG, OPERAND_REG, 1'b0,
            6'd14, 6'd15, 6'd16, 12'h0c0, 16'h0114, 0, 1'b0));
        opTable.push_back(makeOp(2, OP_CLASS_MEM, OPERAND_IMM, OPERAND_REG, 1'b1,
            6'd17, 6'd18, 6'd19, 12'h100, 16'h0118, 0, 1'b0));
        for (int i = 0; i < 8; i++) opTable.push_back(patternOp(3, i, 1'b0));
        for (int i = 0; i < 12; i++) opTable.push_back(patternOp(4, i, 1'b0));
        for (int i = 0; i < 8; i++) opTable.push_back(patternOp(5, i, i == 5));
        for (int i = 0; i < 40; i++) opTable.push_back(randomOp(6));
    endtask

    task automatic setReadyMode(input int mode);
        readyMode = mode;
        issueReady = (mode != ReadyLow) && (mode != ReadyUntilStall);
    endtask

    // Every wait goes through here, so issueReady changes on falling edges only
    task automatic nextCycle();
        @(negedge ctrl);
        if (holdLeft > 0) begin
            issueReady = 1'b0;
            holdLeft--;
        end else if (readyMode == ReadyHigh) begin
            issueReady = 1'b1;
        end else if (readyMode == ReadyRandom) begin
            issueReady = ($urandom % 4) != 0;
        end else begin
            issueReady = 1'b0;
        end
    endtask

    task automatic sendOp(input OpRecord op);
        renValid = 1'b1;
        renOpClass = op.opClass;
        renOperandTypeA = op.typeA;
        renOperandTypeB = op.typeB;
        renWriteReg = op.writeReg;
        renPhyDst = op.dst;
        renPhySrcA = op.srcA;
        renPhySrcB = op.srcB;
        renAluCode = op.raw[3:0];
        renShiftType = op.raw[5:4];
        renBrDisp = op.raw;
        renMemMode = op.raw[7:6];
        renIsLoad = op.raw[8];
        renPc = op.pc;
        // renReady moves only on rising edges
        while (!renReady) begin
            stallSeen = 1'b1;
            stallCycles++;
            if (readyMode == ReadyUntilStall && stallCycles >= 3) setReadyMode(ReadyHigh);
            nextCycle();
        end
        nextCycle();
    endtask

    // The last op is offered again on the flush edge
    // so the stage still holds one when clear arrives
    task automatic applyFlush();
        renValid = 1'b1;
        watch.checkLevel("issueValid before flush", issueValid, 1'b1);
        flush = 1'b1;
        nextCycle();
        flush = 1'b0;
        renValid = 1'b0;
        watch.checkLevel("renReady during flush", renReady, 1'b0);
        nextCycle();
        watch.checkLevel("issueValid after flush", issueValid, 1'b0);
        watch.checkLevel("renReady after flush", renReady, 1'b1);
        setReadyMode(ReadyHigh);
    endtask

    task automatic drainQueue();
        renValid = 1'b0;
        setReadyMode(ReadyHigh);
        while (pendingCount != 0) nextCycle();
        watch.checkLevel("issueValid once drained", issueValid, 1'b0);
    endtask

    task automatic runTest(input int id, input string name, input int mode);
        int errorsBefore;
        int ops;
        int fillOps;
        errorsBefore = errorCount;
        ops = 0;
        fillOps = 0;
        stallSeen = 1'b0;
        stallCycles = 0;
        setReadyMode(mode);
        foreach (opTable[i]) begin
            if (opTable[i].test == id) begin
                if (opTable[i].flushBefore) applyFlush();
                sendOp(opTable[i]);
                ops++;
                // Ops taken before renReady first dropped
                if (!stallSeen) fillOps++;
                if (opTable[i].gap != 0 || id == 1) renValid = 1'b0;
                // The op was taken on the last rising edge and is written on the next one
                if (id == 1) begin
                    watch.checkLevel("issueValid one cycle after accept", issueValid, 1'b0);
                    nextCycle();
                    watch.checkLevel("issueValid two cycles after accept", issueValid, 1'b1);
                end
                holdLeft = opTable[i].gap;
                repeat (opTable[i].gap) nextCycle();
            end
        end
        if (mode == ReadyUntilStall) begin
            watch.checkLevel("renReady low on a full queue", stallSeen, 1'b1);
            // A full queue plus one op held in the stage
            watch.checkLevel("renReady high until queue and stage are full",
                fillOps == `IQ_DEPTH + 1, 1'b1);
        end
        drainQueue();
        testCount++;
        $display("test %0d %s: %0d ops, %0d errors", id, name, ops, errorCount - errorsBefore);
    endtask

    // Watchdog sized from the table
    initial begin
        wait (tableBuilt);
        repeat (opTable.size() * 20) @(posedge ctrl);
        $display("timeout: the run did not finish within %0d cycles", opTable.size() * 20);
        $display("sim failed");
        $finish;
    end

    initial begin
        void'($urandom(22));
        arstN = 1'b0;
        flush = 1'b0;
        renValid = 1'b0;
        renOpClass = OP_CLASS_INT;
        renOperandTypeA = OPERAND_REG;
        renOperandTypeB = OPERAND_REG;
        renWriteReg = 1'b0;
        renPhySrcA = '0;
        renPhySrcB = '0;
        renPhyDst = '0;
        renAluCode = '0;
        renShiftType = '0;
        renBrDisp = '0;
        renMemMode = '0;
        renIsLoad = 1'b0;
        renPc = '0;
        issueReady = 1'b0;
        buildTable();
        tableBuilt = 1'b1;

        repeat (2) @(negedge ctrl);
        arstN = 1'b1;
        watch.checkLevel("renReady after reset", renReady, 1'b1);
        watch.checkLevel("issueValid after reset", issueValid, 1'b0);

        runTest(1, "latency", ReadyLow);
        runTest(2, "classes", ReadyHigh);
        runTest(3, "order", ReadyHigh);
        runTest(4, "backpressure", ReadyUntilStall);
        runTest(5, "flush", ReadyLow);
        runTest(6, "random", ReadyRandom);

        $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule : DispatchTest

//--- test/DispatchChecker.sv
// Scoreboard for the dispatch top level
// Builds the expected entry at each rename transfer and compares it at issue
// Assumes issueReady is low in the cycle after a flush edge

`include "dispatch_settings.svh"

module DispatchChecker (
    input logic ctrl,
    input logic arstN,
    input logic flush,
    input logic renValid,
    input logic renReady,
    input DispatchTypes::OpClass renOpClass,
    input DispatchTypes::OperandType renOperandTypeA,
    input DispatchTypes::OperandType renOperandTypeB,
    input logic renWriteReg,
    input DispatchTypes::PhyRegNum renPhySrcA,
    input DispatchTypes::PhyRegNum renPhySrcB,
    input DispatchTypes::PhyRegNum renPhyDst,
    input DispatchTypes::AluCode renAluCode,
    input DispatchTypes::ShiftType renShiftType,
    input DispatchTypes::BrDisp renBrDisp,
    input DispatchTypes::MemAccessMode renMemMode,
    input logic renIsLoad,
    input DispatchTypes::ProgramCounter renPc,
    input logic issueValid,
    input DispatchTypes::IssueQueueEntry issueEntry,
    input logic issueReady,
    output int errorCount,
    output int checkCount,
    output int pendingCount
);
    import DispatchTypes::*;

    IssueQueueEntry expected[$];
    int compareErrors = 0;
    int compareChecks = 0;
    int levelErrors = 0;
    int levelChecks = 0;

    assign errorCount = compareErrors + levelErrors;
    assign checkCount = compareChecks + levelChecks;

    // Entry for the op now on the rename ports
    function automatic IssueQueueEntry expectedEntry();
        IssueQueueEntry e;
        e.opClass = renOpClass;
        e.writeReg = renWriteReg;
        e.phyDstRegNum = renPhyDst;
        e.srcRegValidA = (renOperandTypeA == OPERAND_REG);
        e.phySrcRegNumA = renPhySrcA;
        e.srcRegValidB = (renOperandTypeB == OPERAND_REG);
        e.phySrcRegNumB = renPhySrcB;
        e.pc = renPc;
        case (renOpClass)
            OP_CLASS_BR: e.subInfo = renBrDisp;
            OP_CLASS_INT: e.subInfo = SubInfo'({renShiftType, renAluCode});
            default: e.subInfo = SubInfo'({renIsLoad, renMemMode});
        endcase
        return e;
    endfunction

    task automatic fieldError(input string field, input string detail);
        $display("mismatch at time %0t: %s %s", $time, field, detail);
        compareErrors++;
    endtask

    task automatic compareEntry(input IssueQueueEntry want);
        compareChecks++;
        if (issueEntry.opClass !== want.opClass)
            fieldError("opClass", $sformatf("expected %0d got %0d",
                want.opClass, issueEntry.opClass));
        if (issueEntry.writeReg !== want.writeReg)
            fieldError("writeReg", $sformatf("expected %b got %b",
                want.writeReg, issueEntry.writeReg));
        if (issueEntry.phyDstRegNum !== want.phyDstRegNum)
            fieldError("phyDstRegNum", $sformatf("expected %h got %h",
                want.phyDstRegNum, issueEntry.phyDstRegNum));
        if (issueEntry.srcRegValidA !== want.srcRegValidA)
            fieldError("srcRegValidA", $sformatf("expected %b got %b",
                want.srcRegValidA, issueEntry.srcRegValidA));
        if (issueEntry.phySrcRegNumA !== want.phySrcRegNumA)
            fieldError("phySrcRegNumA", $sformatf("expected %h got %h",
                want.phySrcRegNumA, issueEntry.phySrcRegNumA));
        if (issueEntry.srcRegValidB !== want.srcRegValidB)
            fieldError("srcRegValidB", $sformatf("expected %b got %b",
                want.srcRegValidB, issueEntry.srcRegValidB));
        if (issueEntry.phySrcRegNumB !== want.phySrcRegNumB)
            fieldError("phySrcRegNumB", $sformatf("expected %h got %h",
                want.phySrcRegNumB, issueEntry.phySrcRegNumB));
        if (issueEntry.subInfo !== want.subInfo)
            fieldError("subInfo", $sformatf("expected %h got %h",
                want.subInfo, issueEntry.subInfo));
        if (issueEntry.pc !== want.pc)
            fieldError("pc", $sformatf("expected %h got %h", want.pc, issueEntry.pc));
    endtask

    // Level check called from the testbench top
    task automatic checkLevel(input string what, input logic actual, input logic want);
        levelChecks++;
        if (actual !== want) begin
            $display("mismatch at time %0t: %s is %b, expected %b", $time, what, actual, want);
            levelErrors++;
        end
    endtask

    always @(posedge ctrl) begin
        if (!arstN) begin
            expected.delete();
        end else begin
            // An entry leaving on the flush edge really left
            // so issue is handled before the flush
            if (issueValid && issueReady) begin
                if (expected.size() == 0) begin
                    $display("ERROR: an entry was issued at time %0t with no op outstanding",
                        $time);
                    compareErrors++;
                end else begin
                    compareEntry(expected.pop_front());
                end
            end
            // Flush drops the op taken on this edge as well
            if (flush) begin
                expected.delete();
            end else if (renValid && renReady) begin
                expected.push_back(expectedEntry());
            end
        end
        pendingCount = expected.size();
    end

endmodule : DispatchChecker

//--- hw/DispatchTop.sv
// Dispatch stage with its controller and in-order issue queue
// Rename and issue sides use valid/ready, issueValid follows occupancy
// flush drops the staged op and every queued entry

module DispatchTop (
    input logic ctrl,
    input logic arstN,
    input logic flush,
    input logic renValid,
    output logic renReady,
    input DispatchTypes::OpClass renOpClass,
    input DispatchTypes::OperandType renOperandTypeA,
    input DispatchTypes::OperandType renOperandTypeB,
    input logic renWriteReg,
    input DispatchTypes::PhyRegNum renPhySrcA,
    input DispatchTypes::PhyRegNum renPhySrcB,
    input DispatchTypes::PhyRegNum renPhyDst,
    input DispatchTypes::AluCode renAluCode,
    input DispatchTypes::ShiftType renShiftType,
    input DispatchTypes::BrDisp renBrDisp,
    input DispatchTypes::MemAccessMode renMemMode,
    input logic renIsLoad,
    input DispatchTypes::ProgramCounter renPc,
    output logic issueValid,
    output DispatchTypes::IssueQueueEntry issueEntry,
    input logic issueReady
);
    import DispatchTypes::*;

    IssueQueueCount count;
    IssueQueuePtr headPtr;
    logic stageValid;
    logic pop;

    DispatchStageIF ctl ();

    // Handshakes on both sides
    assign renReady = !ctl.stall;
    assign issueValid = (count != '0);
    assign pop = issueValid && issueReady;

    DispatchController controller (
        .ctrl(ctrl), .arstN(arstN), .flush(flush),
        .count(count), .stageValid(stageValid), .ctl(ctl)
    );

    IssueQueueAllocator allocator (
        .ctrl(ctrl), .arstN(arstN), .ctl(ctl),
        .pop(pop), .headPtr(headPtr), .count(count)
    );

    DispatchStage stage (
        .ctrl(ctrl), .arstN(arstN), .renValid(renValid),
        .renOpClass(renOpClass), .renOperandTypeA(renOperandTypeA),
        .renOperandTypeB(renOperandTypeB), .renWriteReg(renWriteReg),
        .renPhySrcA(renPhySrcA), .renPhySrcB(renPhySrcB), .renPhyDst(renPhyDst),
        .renAluCode(renAluCode), .renShiftType(renShiftType), .renBrDisp(renBrDisp),
        .renMemMode(renMemMode), .renIsLoad(renIsLoad), .renPc(renPc),
        .ctl(ctl), .stageValid(stageValid)
    );

    IssueQueuePayload payload (
        .ctrl(ctrl), .ctl(ctl), .headPtr(headPtr), .headEntry(issueEntry)
    );

endmodule : DispatchTop

//--- hw/IssueQueuePayload.sv
// Issue queue payload storage
// Entries hold whatever was last written, the allocator decides which are live
// Head read is combinational

`include "dispatch_settings.svh"

module IssueQueuePayload (
    input logic ctrl,
    DispatchStageIF.Payload ctl,
    input DispatchTypes::IssueQueuePtr headPtr,
    output DispatchTypes::IssueQueueEntry headEntry
);
    import DispatchTypes::*;

    IssueQueueEntry entries [`IQ_DEPTH];

    // Single write port from dispatch
    always_ff @(posedge ctrl) begin
        if (ctl.write) begin
            entries[ctl.writePtr] <= ctl.writeData;
        end
    end

    // Oldest entry, presented to the issue side
    assign headEntry = entries[headPtr];

endmodule : IssueQueuePayload

//--- hw/DispatchStage.sv
// Dispatch pipeline register and issue queue entry formatting
// One op per cycle, the register holds while stalled and empties on clear
// Unknown op classes get an all-zero sub-info field

`include "dispatch_settings.svh"

module DispatchStage (
    input logic ctrl,
    input logic arstN,
    input logic renValid,
    input DispatchTypes::OpClass renOpClass,
    input DispatchTypes::OperandType renOperandTypeA,
    input DispatchTypes::OperandType renOperandTypeB,
    input logic renWriteReg,
    input DispatchTypes::PhyRegNum renPhySrcA,
    input DispatchTypes::PhyRegNum renPhySrcB,
    input DispatchTypes::PhyRegNum renPhyDst,
    input DispatchTypes::AluCode renAluCode,
    input DispatchTypes::ShiftType renShiftType,
    input DispatchTypes::BrDisp renBrDisp,
    input DispatchTypes::MemAccessMode renMemMode,
    input logic renIsLoad,
    input DispatchTypes::ProgramCounter renPc,
    DispatchStageIF.Stage ctl,
    output logic stageValid
);
    import DispatchTypes::*;

    localparam int ShiftLsb = `ALU_CODE_WIDTH;
    localparam int IsLoadBit = `MEM_MODE_WIDTH;

    typedef struct packed {
        OpClass opClass;
        OperandType operandTypeA;
        OperandType operandTypeB;
        logic writeReg;
        PhyRegNum phySrcA;
        PhyRegNum phySrcB;
        PhyRegNum phyDst;
        AluCode aluCode;
        ShiftType shiftType;
        BrDisp brDisp;
        MemAccessMode memMode;
        logic isLoad;
        ProgramCounter pc;
    } StageOp;

    logic pipeValid;
    StageOp pipeOp;
    IssueQueueEntry entry;

    // Valid bit of the pipeline register
    always_ff @(posedge ctrl or negedge arstN) begin
        if (!arstN) begin
            pipeValid <= 1'b0;
        end else if (ctl.clear) begin
            pipeValid <= 1'b0;
        end else if (!ctl.stall) begin
            pipeValid <= renValid;
        end
    end

    // Op fields, only meaningful while pipeValid is set
    always_ff @(posedge ctrl) begin
        if (!ctl.stall) begin
            pipeOp.opClass <= renOpClass;
            pipeOp.operandTypeA <= renOperandTypeA;
            pipeOp.operandTypeB <= renOperandTypeB;
            pipeOp.writeReg <= renWriteReg;
            pipeOp.phySrcA <= renPhySrcA;
            pipeOp.phySrcB <= renPhySrcB;
            pipeOp.phyDst <= renPhyDst;
            pipeOp.aluCode <= renAluCode;
            pipeOp.shiftType <= renShiftType;
            pipeOp.brDisp <= renBrDisp;
            pipeOp.memMode <= renMemMode;
            pipeOp.isLoad <= renIsLoad;
            pipeOp.pc <= renPc;
        end
    end

    always_comb begin
        // Shared operand and destination part
        entry.opClass = pipeOp.opClass;
        entry.writeReg = pipeOp.writeReg;
        entry.phyDstRegNum = pipeOp.phyDst;
        entry.srcRegValidA = (pipeOp.operandTypeA == OPERAND_REG);
        entry.phySrcRegNumA = pipeOp.phySrcA;
        entry.srcRegValidB = (pipeOp.operandTypeB == OPERAND_REG);
        entry.phySrcRegNumB = pipeOp.phySrcB;
        entry.pc = pipeOp.pc;

        // Class-dependent part, upper bits stay zero
        entry.subInfo = '0;
        case (pipeOp.opClass)
            OP_CLASS_BR: begin
                entry.subInfo = pipeOp.brDisp;
            end
            OP_CLASS_INT: begin
                entry.subInfo[ShiftLsb-1:0] = pipeOp.aluCode;
                entry.subInfo[ShiftLsb +: `SHIFT_TYPE_WIDTH] = pipeOp.shiftType;
            end
            OP_CLASS_MEM: begin
                entry.subInfo[IsLoadBit-1:0] = pipeOp.memMode;
                entry.subInfo[IsLoadBit] = pipeOp.isLoad;
            end
            default: entry.subInfo = '0;
        endcase
    end

    // Write into the queue only when the op really moves on
    assign ctl.write = pipeValid && !ctl.stall && !ctl.clear;
    assign ctl.writePtr = ctl.tailPtr;
    assign ctl.writeData = entry;
    assign stageValid = pipeValid;

endmodule : DispatchStage

//--- hw/IssueQueueAllocator.sv
// Head, tail and occupancy of the in-order issue queue
// Relies on the controller never writing into a full queue
// and on pop only being raised while count is nonzero

`include "dispatch_settings.svh"

module IssueQueueAllocator (
    input logic ctrl,
    input logic arstN,
    DispatchStageIF.Allocator ctl,
    input logic pop,
    output DispatchTypes::IssueQueuePtr headPtr,
    output DispatchTypes::IssueQueueCount count
);
    import DispatchTypes::*;

    IssueQueuePtr tailPtr;

    // Wraps at IQ_DEPTH, which need not be a power of two
    function automatic IssueQueuePtr nextPtr(input IssueQueuePtr ptr);
        if (ptr == IssueQueuePtr'(`IQ_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge ctrl or negedge arstN) begin
        if (!arstN) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end else if (ctl.clear) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end else begin
            if (ctl.write) begin
                tailPtr <= nextPtr(tailPtr);
            end
            if (pop) begin
                headPtr <= nextPtr(headPtr);
            end
            // Simultaneous write and pop leave the count alone
            case ({ctl.write, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign ctl.tailPtr = tailPtr;

endmodule : IssueQueueAllocator

//--- hw/DispatchController.sv
// Stall and clear generation for the dispatch stage and issue queue
// Goes full one cycle ahead, so a write never lands on a full queue
// A flush holds clear for exactly one cycle

`include "dispatch_settings.svh"

module DispatchController (
    input logic ctrl,
    input logic arstN,
    input logic flush,
    input DispatchTypes::IssueQueueCount count,
    input logic stageValid,
    DispatchStageIF.Controller ctl
);
    import DispatchTypes::*;

    DispatchState state;
    DispatchState nextState;
    IssueQueueCount pending;
    logic noRoom;

    // Queued entries plus the op waiting in the stage
    assign pending = count + IssueQueueCount'(stageValid);

    // No space for the staged op plus one more arrival
    assign noRoom = pending >= IssueQueueCount'(`IQ_DEPTH);

    always_comb begin
        nextState = state;
        if (flush) begin
            nextState = DS_FLUSH;
        end else begin
            case (state)
                DS_RUN: begin
                    if (noRoom) begin
                        nextState = DS_FULL;
                    end
                end
                DS_FULL: begin
                    if (!noRoom) begin
                        nextState = DS_RUN;
                    end
                end
                default: nextState = DS_RUN;
            endcase
        end
    end

    always_ff @(posedge ctrl or negedge arstN) begin
        if (!arstN) begin
            state <= DS_RUN;
        end else begin
            state <= nextState;
        end
    end

    assign ctl.stall = (state != DS_RUN);
    assign ctl.clear = (state == DS_FLUSH);

endmodule : DispatchController

//--- hw/DispatchStageIF.sv
// Controls and payload write bundle between the dispatch blocks
// Carries no clock, every side samples on its own ctrl port

interface DispatchStageIF;
    import DispatchTypes::*;

    // From the controller
    logic stall;
    logic clear;

    // Payload write from the stage
    logic write;
    IssueQueuePtr writePtr;
    IssueQueueEntry writeData;

    // Next free slot from the allocator
    IssueQueuePtr tailPtr;

    modport Controller (output stall, output clear);

    modport Stage (
        input stall, input clear, input tailPtr,
        output write, output writePtr, output writeData
    );

    modport Allocator (input clear, input write, output tailPtr);

    modport Payload (input write, input writePtr, input writeData);

endinterface : DispatchStageIF

//--- hw/DispatchTypes.sv
// Types for the dispatch stage and the in-order issue queue
// Enum encodings are fixed so that a testbench can drive raw values

`include "dispatch_settings.svh"

package DispatchTypes;

    // Plain widths
    typedef logic [`PHY_REG_WIDTH-1:0] PhyRegNum;
    typedef logic [`PC_WIDTH-1:0] ProgramCounter;
    typedef logic [`IQ_PTR_WIDTH-1:0] IssueQueuePtr;
    typedef logic [`IQ_PTR_WIDTH:0] IssueQueueCount;
    typedef logic [`SUB_INFO_WIDTH-1:0] SubInfo;

    // Per-class operand fields from rename
    typedef logic [`ALU_CODE_WIDTH-1:0] AluCode;
    typedef logic [`SHIFT_TYPE_WIDTH-1:0] ShiftType;
    typedef logic [`SUB_INFO_WIDTH-1:0] BrDisp;
    typedef logic [`MEM_MODE_WIDTH-1:0] MemAccessMode;

    typedef enum logic [1:0] {
        OP_CLASS_INT = 2'd0,
        OP_CLASS_BR  = 2'd1,
        OP_CLASS_MEM = 2'd2
    } OpClass;

    typedef enum logic {
        OPERAND_REG = 1'b0,
        OPERAND_IMM = 1'b1
    } OperandType;

    // Controller states
    typedef enum logic [1:0] {
        DS_RUN   = 2'd0,
        DS_FULL  = 2'd1,
        DS_FLUSH = 2'd2
    } DispatchState;

    // One issue queue payload slot
    // subInfo layout depends on opClass
    typedef struct packed {
        OpClass opClass;
        logic writeReg;
        PhyRegNum phyDstRegNum;
        logic srcRegValidA;
        PhyRegNum phySrcRegNumA;
        logic srcRegValidB;
        PhyRegNum phySrcRegNumB;
        SubInfo subInfo;
        ProgramCounter pc;
    } IssueQueueEntry;

endpackage : DispatchTypes

//--- hw/dispatch_settings.svh
// Widths and sizes shared by the dispatch stage and the issue queue
// IQ_PTR_WIDTH must equal clog2(IQ_DEPTH), and IQ_DEPTH must fit in IQ_PTR_WIDTH + 1 bits
// Integer and memory sub-info fields must fit within SUB_INFO_WIDTH
`ifndef DISPATCH_SETTINGS_SVH
`define DISPATCH_SETTINGS_SVH

// Register file and program counter
`define PHY_REG_WIDTH 6
`define PC_WIDTH 16

// Issue queue geometry
`define IQ_DEPTH 8
`define IQ_PTR_WIDTH 3

// Class-dependent fields
`define SUB_INFO_WIDTH 12
`define ALU_CODE_WIDTH 4
`define SHIFT_TYPE_WIDTH 2
`define MEM_MODE_WIDTH 2

`endif
